/* usb_rx.f */
+incdir+source
source/usb_line_pkg.sv
source/usb_rx_pkg.sv
source/usb_line_sync.sv
source/usb_bit_timer.sv
source/usb_nrzi_decoder.sv
source/usb_byte_assembler.sv
source/usb_rx_credit_out.sv
source/usb_rx_top.sv
verif/tb_clock_gen.sv
verif/tb_usb_rx.sv

/* Bender.yml */
package:
  name: usb_rx

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/usb_line_pkg.sv
      - source/usb_rx_pkg.sv
      - source/usb_line_sync.sv
      - source/usb_bit_timer.sv
      - source/usb_nrzi_decoder.sv
      - source/usb_byte_assembler.sv
      - source/usb_rx_credit_out.sv
      - source/usb_rx_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_usb_rx.sv

/* verif/tb_usb_rx.sv */
// USB receive front end testbench
// Encodes packets onto dp/dm, models a credit consumer and checks the entry stream
`timescale 1ns/1ps
`default_nettype none
`include "usb_rx_consts.svh"

module tb_usb_rx;

	// Bits on the wire: SYNC and EOP per packet, payload, worst-case stuffing
	localparam int PAYLOAD_BYTES = 21;
	localparam int SENT_BITS     = 5 * 11 + PAYLOAD_BYTES * 8 + PAYLOAD_BYTES * 8 / 6;
	localparam int SETTLE_BITS   = 16;
	localparam int SETTLE_COUNT  = 8;
	localparam int TIMEOUT_CYCLES =
		(SENT_BITS + SETTLE_BITS * SETTLE_COUNT) * `USB_RX_CLKS_PER_BIT + 500;

	logic                 tb_clk;
	logic                 rst_n;
	logic                 usb_dp;
	logic                 usb_dm;
	logic                 credit_return = 1'b0;
	logic                 rx_valid;
	usb_rx_pkg::rx_kind_e rx_kind;
	usb_rx_pkg::rx_byte_t rx_data;
	logic                 rx_overflow;

	// Consumer state
	logic                 hold;
	logic                 ret_pending;
	int                   held_credits;
	usb_rx_pkg::rx_kind_e got_kind [64];
	usb_rx_pkg::rx_byte_t got_data [64];
	int                   got_count;

	// Stimulus state
	usb_rx_pkg::rx_byte_t tx_bytes [16];
	int                   tx_len;
	logic                 level_j;
	integer               seed;
	int                   cycle_count;
	int                   error_count;
	int                   test_errors;
	int                   tests_run;
	int                   tests_failed;

	tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(8)) i_clock_gen (
		.tb_clk (tb_clk),
		.rst_n  (rst_n)
	);

	usb_rx_top i_dut (
		.tb_clk        (tb_clk),
		.rst_n         (rst_n),
		.usb_dp        (usb_dp),
		.usb_dm        (usb_dm),
		.credit_return (credit_return),
		.rx_valid      (rx_valid),
		.rx_kind       (rx_kind),
		.rx_data       (rx_data),
		.rx_overflow   (rx_overflow)
	);

	// Consumer, records entries and returns one credit per entry
	always @(posedge tb_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ret_pending   <= 1'b0;
			credit_return <= 1'b0;
			held_credits  = 0;
			got_count     = 0;
		end
		else
		begin
			if (rx_valid)
			begin
				got_kind[got_count] = rx_kind;
				got_data[got_count] = rx_data;
				got_count = got_count + 1;
				if (hold)
					held_credits = held_credits + 1;
			end
			ret_pending <= rx_valid && !hold;
			// Held credits go back one per cycle once the hold clears
			if (ret_pending)
				credit_return <= 1'b1;
			else if (!hold && held_credits > 0)
			begin
				credit_return <= 1'b1;
				held_credits = held_credits - 1;
			end
			else
				credit_return <= 1'b0;
		end
	end

	// Watchdog
	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge tb_clk);
			cycle_count = cycle_count + 1;
		end
		$display("Timeout after %0d cycles, the DUT stopped delivering entries", cycle_count);
		$display("TESTBENCH FAILED");
		$finish;
	end

	task automatic check_kind(input string name, input usb_rx_pkg::rx_kind_e got,
		input usb_rx_pkg::rx_kind_e exp);
		if (got !== exp)
		begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			test_errors = test_errors + 1;
		end
	endtask

	task automatic check_data(input string name, input usb_rx_pkg::rx_byte_t got,
		input usb_rx_pkg::rx_byte_t exp);
		if (got !== exp)
		begin
			$display("ERROR %s: got 0x%02h, expected 0x%02h", name, got, exp);
			test_errors = test_errors + 1;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			test_errors = test_errors + 1;
		end
	endtask

	task automatic expect_entry_count(input string what, input int got, input int exp);
		if (got != exp)
		begin
			$display("Expected %0d entries %s, but %0d arrived", exp, what, got);
			test_errors = test_errors + 1;
		end
	endtask

	task automatic report_test(input string name);
		tests_run = tests_run + 1;
		error_count = error_count + test_errors;
		if (test_errors == 0)
			$display("test %s: ok", name);
		else
		begin
			tests_failed = tests_failed + 1;
			$display("test %s: failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// Idle the lines for a number of bit times, end away from the clock edge
	task automatic settle(input int bits);
		repeat (bits * `USB_RX_CLKS_PER_BIT)
			@(posedge tb_clk);
		@(negedge tb_clk);
	endtask

	task automatic wait_entries(input int n);
		while (got_count < n)
			@(negedge tb_clk);
	endtask

	task automatic fill_random(input int len);
		integer rnd;
		tx_len = len;
		for (int i = 0; i < len; i++)
		begin
			rnd = $random(seed);
			tx_bytes[i] = rnd[7:0];
		end
	endtask

	// One bus bit, held for a full bit time
	task automatic drive_line(input logic dp, input logic dm);
		@(posedge tb_clk);
		usb_dp <= dp;
		usb_dm <= dm;
		repeat (`USB_RX_CLKS_PER_BIT - 1)
			@(posedge tb_clk);
	endtask

	// NRZI, a zero toggles J/K and a one keeps the level
	task automatic send_bit(input logic b);
		if (!b)
			level_j = !level_j;
		drive_line(level_j, !level_j);
	endtask

	// SYNC, payload lsb first with optional stuffing, then SE0 SE0 J
	task automatic send_packet(input bit stuff_on);
		usb_rx_pkg::rx_byte_t cur;
		int                   ones;
		level_j = 1'b1;
		ones = 0;
		for (int n = 0; n <= tx_len; n++)
		begin
			cur = (n == 0) ? usb_rx_pkg::rx_byte_t'(`USB_RX_SYNC_BYTE) : tx_bytes[n - 1];
			for (int b = 0; b < 8; b++)
			begin
				send_bit(cur[b]);
				ones = cur[b] ? ones + 1 : 0;
				if (stuff_on && ones == `USB_RX_STUFF_LIMIT)
				begin
					send_bit(1'b0);
					ones = 0;
				end
			end
		end
		drive_line(1'b0, 1'b0);
		drive_line(1'b0, 1'b0);
		drive_line(1'b1, 1'b0);
	endtask

	// Data entries in send order, then end of packet
	task automatic check_packet(input int base);
		for (int i = 0; i < tx_len; i++)
		begin
			check_kind("rx_kind", got_kind[base + i], usb_rx_pkg::RX_DATA);
			check_data("rx_data", got_data[base + i], tx_bytes[i]);
		end
		check_kind("rx_kind", got_kind[base + tx_len], usb_rx_pkg::RX_EOP);
	endtask

	task automatic test_idle();
		settle(SETTLE_BITS);
		expect_entry_count("on an idle bus", got_count, 0);
		check_flag("rx_overflow", rx_overflow, 1'b0);
		report_test("idle");
	endtask

	task automatic test_random_pair();
		int base;
		base = got_count;
		fill_random(2);
		send_packet(1'b1);
		wait_entries(base + 3);
		check_packet(base);
		settle(SETTLE_BITS);
		expect_entry_count("for a two-byte packet", got_count - base, 3);
		report_test("random_pair");
	endtask

	task automatic test_stuffed_bytes();
		int base;
		base = got_count;
		tx_len = 2;
		tx_bytes[0] = 8'hff;
		tx_bytes[1] = 8'h7e;
		send_packet(1'b1);
		wait_entries(base + 3);
		check_packet(base);
		settle(SETTLE_BITS);
		report_test("stuffed_bytes");
	endtask

	// Stuffing left out, so the run of ones breaks the rule
	task automatic test_stuff_error();
		int base;
		base = got_count;
		tx_len = 1;
		tx_bytes[0] = 8'hff;
		send_packet(1'b0);
		wait_entries(base + 1);
		check_kind("rx_kind", got_kind[base], usb_rx_pkg::RX_ERROR);
		settle(SETTLE_BITS);
		expect_entry_count("after a stuffing error", got_count - base, 1);
		report_test("stuff_error");
	endtask

	task automatic test_held_credits();
		int base;
		base = got_count;
		@(posedge tb_clk);
		hold <= 1'b1;
		fill_random(6);
		send_packet(1'b1);
		settle(SETTLE_BITS);
		expect_entry_count("while credits were held", got_count - base, `USB_RX_CREDITS);
		@(posedge tb_clk);
		hold <= 1'b0;
		wait_entries(base + 7);
		check_packet(base);
		settle(SETTLE_BITS);
		check_flag("rx_overflow", rx_overflow, 1'b0);
		report_test("held_credits");
	endtask

	// Credits and FIFO fill up, the tail of the packet is lost
	task automatic test_overflow();
		int base;
		int kept;
		base = got_count;
		kept = `USB_RX_CREDITS + `USB_RX_QUEUE_DEPTH;
		@(posedge tb_clk);
		hold <= 1'b1;
		fill_random(10);
		send_packet(1'b1);
		settle(SETTLE_BITS);
		check_flag("rx_overflow", rx_overflow, 1'b1);
		expect_entry_count("while credits were held", got_count - base, `USB_RX_CREDITS);
		@(posedge tb_clk);
		hold <= 1'b0;
		wait_entries(base + kept);
		settle(SETTLE_BITS);
		expect_entry_count("after release", got_count - base, kept);
		for (int i = 0; i < kept; i++)
		begin
			check_kind("rx_kind", got_kind[base + i], usb_rx_pkg::RX_DATA);
			check_data("rx_data", got_data[base + i], tx_bytes[i]);
		end
		check_flag("rx_overflow", rx_overflow, 1'b1);
		report_test("overflow");
	endtask

	initial
	begin
		seed = 32'hff55_1fb1;
		usb_dp = 1'b1;
		usb_dm = 1'b0;
		hold = 1'b0;
		level_j = 1'b1;
		error_count = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		wait (rst_n === 1'b1);
		@(negedge tb_clk);
		test_idle();
		test_random_pair();
		test_stuffed_bytes();
		test_stuff_error();
		test_held_credits();
		test_overflow();
		$display("%0d tests run, %0d failed, %0d check errors",
			tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// Testbench clock and reset
// Free-running clock and an active-low reset held for a few cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 8
) (
	output logic tb_clk,
	output logic rst_n
);

	initial
	begin
		tb_clk = 1'b0;
		forever
			#(PERIOD_NS / 2) tb_clk = !tb_clk;
	end

	// Release on a rising edge, like any other input
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge tb_clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* source/usb_rx_top.sv */
// USB full-speed receive front end
// Line sync, bit timing, NRZI decode, byte assembly and credit output
`timescale 1ns/1ps
`default_nettype none

module usb_rx_top (
	input  wire                  tb_clk,
	input  wire                  rst_n,
	input  wire                  usb_dp,
	input  wire                  usb_dm,
	input  wire                  credit_return,
	output logic                 rx_valid,
	output usb_rx_pkg::rx_kind_e rx_kind,
	output usb_rx_pkg::rx_byte_t rx_data,
	output logic                 rx_overflow
);

	usb_line_pkg::line_state_e line_state;
	logic                      line_edge;
	logic                      shift_enable;
	logic                      bit_valid;
	logic                      bit_data;
	logic                      stuff_error;
	logic                      eop;
	logic                      push;
	usb_rx_pkg::rx_kind_e      push_kind;
	usb_rx_pkg::rx_byte_t      push_data;

	usb_line_sync i_line_sync (
		.tb_clk     (tb_clk),
		.rst_n      (rst_n),
		.usb_dp     (usb_dp),
		.usb_dm     (usb_dm),
		.line_state (line_state),
		.line_edge  (line_edge)
	);

	usb_bit_timer i_bit_timer (
		.tb_clk       (tb_clk),
		.rst_n        (rst_n),
		.line_edge    (line_edge),
		.shift_enable (shift_enable)
	);

	usb_nrzi_decoder i_nrzi_decoder (
		.tb_clk       (tb_clk),
		.rst_n        (rst_n),
		.line_state   (line_state),
		.shift_enable (shift_enable),
		.bit_valid    (bit_valid),
		.bit_data     (bit_data),
		.stuff_error  (stuff_error),
		.eop          (eop)
	);

	usb_byte_assembler i_byte_assembler (
		.tb_clk      (tb_clk),
		.rst_n       (rst_n),
		.bit_valid   (bit_valid),
		.bit_data    (bit_data),
		.stuff_error (stuff_error),
		.eop         (eop),
		.push        (push),
		.push_kind   (push_kind),
		.push_data   (push_data)
	);

	usb_rx_credit_out i_credit_out (
		.tb_clk        (tb_clk),
		.rst_n         (rst_n),
		.push          (push),
		.push_kind     (push_kind),
		.push_data     (push_data),
		.credit_return (credit_return),
		.rx_valid      (rx_valid),
		.rx_kind       (rx_kind),
		.rx_data       (rx_data),
		.rx_overflow   (rx_overflow)
	);

endmodule

`default_nettype wire

/* source/usb_rx_credit_out.sv */
// USB receive output stage
// Small FIFO of entries toward the consumer, released one per cycle
// against a credit counter; a push into a full FIFO sets a sticky overflow
`timescale 1ns/1ps
`default_nettype none
`include "usb_rx_consts.svh"

module usb_rx_credit_out (
	input  wire                       tb_clk,
	input  wire                       rst_n,
	input  wire                       push,
	input  wire usb_rx_pkg::rx_kind_e push_kind,
	input  wire usb_rx_pkg::rx_byte_t push_data,
	input  wire                       credit_return,
	output logic                      rx_valid,
	output usb_rx_pkg::rx_kind_e      rx_kind,
	output usb_rx_pkg::rx_byte_t      rx_data,
	output logic                      rx_overflow
);

	localparam int DEPTH = `USB_RX_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CRD_W = $clog2(`USB_RX_CREDITS + 1);
	localparam logic [CRD_W-1:0] MAX_CREDITS = CRD_W'(`USB_RX_CREDITS);

	usb_rx_pkg::rx_kind_e kind_mem [DEPTH];
	usb_rx_pkg::rx_byte_t data_mem [DEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [CNT_W-1:0]     count;
	logic [CRD_W-1:0]     credits;
	logic                 empty;
	logic                 full;
	logic                 pop;
	logic                 bypass;
	logic                 do_write;
	logic                 do_read;
	logic                 do_return;

	assign empty     = (count == '0);
	assign full      = (count == CNT_W'(DEPTH));
	// Head is the stored entry, or the incoming one when empty
	assign pop       = (!empty || push) && (credits != '0);
	assign bypass    = empty && push && pop;
	assign do_write  = push && !full && !bypass;
	assign do_read   = pop && !empty;
	// Extra returns beyond the grant are ignored
	assign do_return = credit_return && (credits != MAX_CREDITS || pop);

	always_ff @(posedge tb_clk)
	begin
		if (do_write)
		begin
			kind_mem[wr_ptr] <= push_kind;
			data_mem[wr_ptr] <= push_data;
		end
		if (pop)
		begin
			rx_kind <= empty ? push_kind : kind_mem[rd_ptr];
			rx_data <= empty ? push_data : data_mem[rd_ptr];
		end
	end

	always_ff @(posedge tb_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			credits     <= MAX_CREDITS;
			rx_valid    <= 1'b0;
			rx_overflow <= 1'b0;
		end
		else
		begin
			rx_valid <= pop;
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			count   <= count + CNT_W'(do_write) - CNT_W'(do_read);
			credits <= credits - CRD_W'(pop) + CRD_W'(do_return);
			// Sticky until reset
			if (push && full)
				rx_overflow <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/usb_byte_assembler.sv */
// USB byte assembler
// Hunts for SYNC in the decoded bit stream, then packs bits lsb first
// into bytes and pushes data, end-of-packet and error entries
`timescale 1ns/1ps
`default_nettype none
`include "usb_rx_consts.svh"

module usb_byte_assembler (
	input  wire                  tb_clk,
	input  wire                  rst_n,
	input  wire                  bit_valid,
	input  wire                  bit_data,
	input  wire                  stuff_error,
	input  wire                  eop,
	output logic                 push,
	output usb_rx_pkg::rx_kind_e push_kind,
	output usb_rx_pkg::rx_byte_t push_data
);

	logic                 in_packet;
	logic [2:0]           bit_cnt;
	usb_rx_pkg::rx_byte_t shift_reg;
	usb_rx_pkg::rx_byte_t next_shift;

	// New bit enters at the top, first bit ends in bit 0
	assign next_shift = {bit_data, shift_reg[7:1]};

	always_ff @(posedge tb_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			in_packet <= 1'b0;
			bit_cnt   <= 3'd0;
			// All ones can never look like SYNC
			shift_reg <= 8'hff;
			push      <= 1'b0;
			push_kind <= usb_rx_pkg::RX_DATA;
			push_data <= 8'h00;
		end
		else
		begin
			push <= 1'b0;
			if (bit_valid)
			begin
				shift_reg <= next_shift;
				if (!in_packet)
				begin
					// Hunting
					if (next_shift == `USB_RX_SYNC_BYTE)
					begin
						in_packet <= 1'b1;
						bit_cnt   <= 3'd0;
					end
				end
				else
				begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
					begin
						push      <= 1'b1;
						push_kind <= usb_rx_pkg::RX_DATA;
						push_data <= next_shift;
					end
				end
			end
			else if ((eop || stuff_error) && in_packet)
			begin
				// Partial bits are dropped, back to hunting
				push      <= 1'b1;
				push_kind <= eop ? usb_rx_pkg::RX_EOP : usb_rx_pkg::RX_ERROR;
				push_data <= 8'h00;
				in_packet <= 1'b0;
				shift_reg <= 8'hff;
			end
		end
	end

endmodule

`default_nettype wire

/* source/usb_nrzi_decoder.sv */
// USB NRZI decoder
// Turns sampled J/K levels into bits, removes stuffed zeros,
// reports stuffing violations and the first SE0 as end of packet
`timescale 1ns/1ps
`default_nettype none
`include "usb_rx_consts.svh"

module usb_nrzi_decoder (
	input  wire                        tb_clk,
	input  wire                        rst_n,
	input  wire usb_line_pkg::line_state_e line_state,
	input  wire                        shift_enable,
	output logic                       bit_valid,
	output logic                       bit_data,
	output logic                       stuff_error,
	output logic                       eop
);

	localparam logic [2:0] STUFF_LIMIT = 3'(`USB_RX_STUFF_LIMIT);
	// Run counter parked here while idle, no stuffing checks
	localparam logic [2:0] RUN_IDLE    = STUFF_LIMIT + 3'd1;

	usb_line_pkg::line_state_e prev_level;
	logic [2:0]                ones_run;
	logic                      in_se0;
	logic                      decoded;

	// No transition means a one
	assign decoded = (line_state == prev_level);

	always_ff @(posedge tb_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			prev_level  <= usb_line_pkg::LINE_J;
			ones_run    <= RUN_IDLE;
			in_se0      <= 1'b0;
			bit_valid   <= 1'b0;
			bit_data    <= 1'b0;
			stuff_error <= 1'b0;
			eop         <= 1'b0;
		end
		else
		begin
			bit_valid   <= 1'b0;
			stuff_error <= 1'b0;
			eop         <= 1'b0;
			if (shift_enable)
			begin
				if (line_state == usb_line_pkg::LINE_SE0)
				begin
					// Only the first SE0 sample ends the packet
					if (!in_se0)
						eop <= 1'b1;
					in_se0     <= 1'b1;
					prev_level <= usb_line_pkg::LINE_J;
					ones_run   <= RUN_IDLE;
				end
				else if (line_state != usb_line_pkg::LINE_SE1)
				begin
					if (line_state == usb_line_pkg::LINE_J)
						in_se0 <= 1'b0;
					prev_level <= line_state;
					if (ones_run == STUFF_LIMIT)
					begin
						// Zero here is the stuffed bit, drop it
						if (decoded)
						begin
							stuff_error <= 1'b1;
							ones_run    <= RUN_IDLE;
						end
						else
							ones_run <= 3'd0;
					end
					else
					begin
						bit_valid <= 1'b1;
						bit_data  <= decoded;
						if (!decoded)
							ones_run <= 3'd0;
						else if (ones_run != RUN_IDLE)
							ones_run <= ones_run + 3'd1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* source/usb_bit_timer.sv */
// USB bit timer
// Free-running bit-phase counter that re-centers on line edges
// and strobes once per bit at the sampling phase
`timescale 1ns/1ps
`default_nettype none
`include "usb_rx_consts.svh"

module usb_bit_timer (
	input  wire   tb_clk,
	input  wire   rst_n,
	input  wire   line_edge,
	output logic  shift_enable
);

	localparam logic [3:0] LAST_PHASE   = 4'(`USB_RX_CLKS_PER_BIT - 1);
	localparam logic [3:0] SAMPLE_PHASE = 4'(`USB_RX_SAMPLE_PHASE);

	logic [3:0] phase;

	always_ff @(posedge tb_clk or negedge rst_n)
	begin
		if (!rst_n)
			phase <= 4'd0;
		else if (line_edge)
			// Edge marks the start of a bit
			phase <= 4'd0;
		else if (phase == LAST_PHASE)
			phase <= 4'd0;
		else
			phase <= phase + 4'd1;
	end

	// Sample a few clocks into the bit and away from the transition
	// No strobe in an edge cycle as the new bit is sampled once after re-phasing
	assign shift_enable = (phase == SAMPLE_PHASE) && !line_edge;

endmodule

`default_nettype wire

/* source/usb_line_sync.sv */
// USB line synchronizer
// Double-registers dp and dm, classifies the pair into a line state
// and flags every change of state as an edge
`timescale 1ns/1ps
`default_nettype none

module usb_line_sync (
	input  wire                         tb_clk,
	input  wire                         rst_n,
	input  wire                         usb_dp,
	input  wire                         usb_dm,
	output usb_line_pkg::line_state_e   line_state,
	output logic                        line_edge
);

	logic                       dp_meta;
	logic                       dp_sync;
	logic                       dm_meta;
	logic                       dm_sync;
	usb_line_pkg::line_state_e  prev_state;

	// Two-flop synchronizers, idle bus is J
	always_ff @(posedge tb_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			dp_meta    <= 1'b1;
			dp_sync    <= 1'b1;
			dm_meta    <= 1'b0;
			dm_sync    <= 1'b0;
			prev_state <= usb_line_pkg::LINE_J;
		end
		else
		begin
			dp_meta    <= usb_dp;
			dp_sync    <= dp_meta;
			dm_meta    <= usb_dm;
			dm_sync    <= dm_meta;
			// Last state, for edge detection
			prev_state <= line_state;
		end
	end

	// Map the synchronized pair onto a line state
	always_comb
	begin
		case ({dp_sync, dm_sync})
			2'b10:   line_state = usb_line_pkg::LINE_J;
			2'b01:   line_state = usb_line_pkg::LINE_K;
			2'b00:   line_state = usb_line_pkg::LINE_SE0;
			default: line_state = usb_line_pkg::LINE_SE1;
		endcase
	end

	// Edge in the cycle the state changes
	assign line_edge = (line_state != prev_state);

endmodule

`default_nettype wire

/* source/usb_rx_pkg.sv */
// USB receive entry stream types
// Entry kinds and payload handed from the assembler to the consumer
`default_nettype none

package usb_rx_pkg;

	// Kind of one entry in the receive stream
	typedef enum logic [1:0]
	{
		// Payload byte, includes PID and CRC bytes
		RX_DATA  = 2'd0,
		// Packet ended on SE0
		RX_EOP   = 2'd1,
		// Stuffing violation inside a packet
		RX_ERROR = 2'd2
	} rx_kind_e;

	// One received byte
	typedef logic [7:0] rx_byte_t;

endpackage

`default_nettype wire

/* source/usb_line_pkg.sv */
// USB bus line types
// Classification of the dp/dm pair as seen by the receiver
`default_nettype none

package usb_line_pkg;

	// Line state after synchronization
	// J is dp high, K is dm high for full speed
	typedef enum logic [1:0]
	{
		LINE_J   = 2'd0,
		LINE_K   = 2'd1,
		// Both low, end of packet or reset
		LINE_SE0 = 2'd2,
		// Both high, illegal on the bus
		LINE_SE1 = 2'd3
	} line_state_e;

endpackage

`default_nettype wire

/* source/usb_rx_consts.svh */
// USB full-speed receive constants
// Bit timing, SYNC pattern, stuffing limit and output queue sizing
`ifndef USB_RX_CONSTS_SVH
`define USB_RX_CONSTS_SVH

// Clocks per bus bit; the phase counter is 4 bits wide
`define USB_RX_CLKS_PER_BIT 8

// Counter value at which a bit is sampled
`define USB_RX_SAMPLE_PHASE 3

// SYNC as decoded, lsb first (KJKJKJKK)
`define USB_RX_SYNC_BYTE 8'h80

// Ones in a row before a zero is stuffed
`define USB_RX_STUFF_LIMIT 6

// Output queue depth and credits granted after reset
`define USB_RX_QUEUE_DEPTH 4
`define USB_RX_CREDITS 4

`endif
